//--- src/pi1_bus_pkg.sv
// Peripheral bus widths, payload types and operation codes, imported by every bus module
package pi1_bus_pkg;

	// Data width and derived word address width
	localparam int ARCHBITSZ = 32;
	localparam int ADDRBITSZ = ARCHBITSZ - 2;

	// One select bit per byte lane
	localparam int SELBITSZ = ARCHBITSZ / 8;

	// Bus operations on a two-bit code
	typedef enum logic [1:0] {
		PI1_NOOP = 2'b00,
		PI1_WROP = 2'b01,
		PI1_RDOP = 2'b10,
		// Writes new data and returns the old word
		PI1_RWOP = 2'b11
	} pi1_op_e;

	typedef logic [ARCHBITSZ-1:0] pi1_data_t;
	typedef logic [ADDRBITSZ-1:0] pi1_addr_t;
	typedef logic [SELBITSZ-1:0]  pi1_sel_t;

	// Cycles from acceptance until ready rises again
	localparam int RESP_LATENCY = 2;

endpackage

//--- src/soc_map_pkg.sv
// System address map, slave list, device ids and software reset codes for the fabric
package soc_map_pkg;

	// Slaves in address order, the last one catches unmapped accesses
	typedef enum logic [1:0] {
		S_DEVTBL     = 2'd0,
		S_RAM        = 2'd1,
		S_INVALIDDEV = 2'd2
	} slave_idx_e;

	localparam int SLAVECOUNT = 3;

	// Window sizes in words
	localparam int DEVTBL_MAPSZ     = 16;
	localparam int RAM_MAPSZ        = 256;
	// 4 KB of words
	localparam int INVALIDDEV_MAPSZ = 1024;

	// Base word addresses, windows packed from address 0
	localparam int DEVTBL_BASE     = 0;
	localparam int RAM_BASE        = DEVTBL_BASE + DEVTBL_MAPSZ;
	localparam int INVALIDDEV_BASE = RAM_BASE + RAM_MAPSZ;

	// Ids reported by the device table
	localparam int DEVID_DEVTBL     = 7;
	localparam int DEVID_RAM        = 1;
	localparam int DEVID_INVALIDDEV = 0;

	// Reset register sits in the last word of the device table
	localparam int RSTREG_OFFSET = 15;

	// Software reset codes, bit 0 is rst0 and bit 1 is rst1
	typedef enum logic [1:0] {
		RST_NONE   = 2'd0,
		RST_PWROFF = 2'd1,
		RST_WARM   = 2'd2
	} sw_rst_e;

	localparam int RST_CNTR_BITSZ = 8;

endpackage

//--- src/reset_sequencer.sv
// Reset counter and power-off latch driving the core reset and the status LEDs
`timescale 1ns/1ps

module reset_sequencer (
	input  logic                 clk48mhz_i,
	input  logic                 rst_p,
	input  logic                 sw_rst_req_i,
	input  soc_map_pkg::sw_rst_e sw_rst_code_i,
	output logic                 core_rst_o,
	output logic                 led_green_n_o,
	output logic                 led_red_n_o
);

	import soc_map_pkg::*;

	logic [RST_CNTR_BITSZ-1:0] rst_cntr;
	logic                      pwroff_q;
	logic                      warm_req;
	logic                      pwroff_req;

	assign warm_req   = sw_rst_req_i && (sw_rst_code_i == RST_WARM);
	assign pwroff_req = sw_rst_req_i && (sw_rst_code_i == RST_PWROFF);

	// Counter reloads on the button or a warm reset, then runs down to zero
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			rst_cntr <= '1;
		end else if (warm_req) begin
			rst_cntr <= '1;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// Power-off holds the core in reset until the next button press
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (pwroff_req) begin
			pwroff_q <= 1'b1;
		end
	end

	assign core_rst_o = (rst_cntr != '0) || pwroff_q;

	// Green on while running, red on while powered off, both active low
	assign led_green_n_o = core_rst_o;
	assign led_red_n_o   = !pwroff_q;

endmodule

//--- src/pi1_addr_decoder.sv
// Bus input stage; accepts a master request, registers it and selects the target slave
`timescale 1ns/1ps

module pi1_addr_decoder (
	input  logic                    clk48mhz_i,
	input  logic                    rst_p,
	input  logic                    core_rst_i,
	input  pi1_bus_pkg::pi1_op_e    pi1_op_i,
	input  pi1_bus_pkg::pi1_addr_t  pi1_addr_i,
	input  pi1_bus_pkg::pi1_data_t  pi1_data_i,
	input  pi1_bus_pkg::pi1_sel_t   pi1_sel_i,
	output logic                    busy_o,
	output logic                    req_valid_o,
	output pi1_bus_pkg::pi1_op_e    req_op_o,
	output pi1_bus_pkg::pi1_addr_t  req_offset_o,
	output pi1_bus_pkg::pi1_data_t  req_data_o,
	output pi1_bus_pkg::pi1_sel_t   req_sel_o,
	output soc_map_pkg::slave_idx_e slave_sel_o,
	input  logic                    done_i
);

	import pi1_bus_pkg::*;
	import soc_map_pkg::*;

	logic       accept;
	slave_idx_e sel_nxt;
	pi1_addr_t  base_nxt;

	// Only one request in flight, nothing taken during core reset
	assign accept = !busy_o && !core_rst_i && (pi1_op_i != PI1_NOOP);

	// Anything at or above the last window goes to the default slave
	always_comb begin
		if (pi1_addr_i >= pi1_addr_t'(INVALIDDEV_BASE)) begin
			sel_nxt  = S_INVALIDDEV;
			base_nxt = pi1_addr_t'(INVALIDDEV_BASE);
		end else if (pi1_addr_i >= pi1_addr_t'(RAM_BASE)) begin
			sel_nxt  = S_RAM;
			base_nxt = pi1_addr_t'(RAM_BASE);
		end else begin
			sel_nxt  = S_DEVTBL;
			base_nxt = pi1_addr_t'(DEVTBL_BASE);
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p || core_rst_i) begin
			busy_o      <= 1'b0;
			req_valid_o <= 1'b0;
			slave_sel_o <= S_INVALIDDEV;
		end else begin
			req_valid_o <= accept;
			if (accept) begin
				busy_o      <= 1'b1;
				slave_sel_o <= sel_nxt;
			end else if (done_i) begin
				busy_o <= 1'b0;
			end
		end
	end

	// Request payload
	always_ff @(posedge clk48mhz_i) begin
		if (accept) begin
			req_op_o     <= pi1_op_i;
			req_offset_o <= pi1_addr_i - base_nxt;
			req_data_o   <= pi1_data_i;
			req_sel_o    <= pi1_sel_i;
		end
	end

endmodule

//--- src/device_table.sv
// Device table slave; reports id, interrupt flag and map size per slave, holds the reset register
`timescale 1ns/1ps

module device_table (
	input  logic                   clk48mhz_i,
	input  logic                   rst_p,
	input  logic                   req_valid_i,
	input  pi1_bus_pkg::pi1_op_e   req_op_i,
	input  pi1_bus_pkg::pi1_addr_t req_offset_i,
	input  pi1_bus_pkg::pi1_data_t req_data_i,
	output pi1_bus_pkg::pi1_data_t rd_data_o,
	output logic                   sw_rst_req_o,
	output soc_map_pkg::sw_rst_e   sw_rst_code_o
);

	import pi1_bus_pkg::*;
	import soc_map_pkg::*;

	logic [15:0]                   id_tbl    [SLAVECOUNT];
	logic                          intr_tbl  [SLAVECOUNT];
	pi1_data_t                     mapsz_tbl [SLAVECOUNT];
	logic [$clog2(SLAVECOUNT)-1:0] slot;
	pi1_data_t                     rd_nxt;
	logic [1:0]                    rst_bits;
	logic                          rst_wr;

	assign id_tbl[S_DEVTBL]     = 16'(DEVID_DEVTBL);
	assign id_tbl[S_RAM]        = 16'(DEVID_RAM);
	assign id_tbl[S_INVALIDDEV] = 16'(DEVID_INVALIDDEV);

	// No slave in this system raises interrupts
	assign intr_tbl[S_DEVTBL]     = 1'b0;
	assign intr_tbl[S_RAM]        = 1'b0;
	assign intr_tbl[S_INVALIDDEV] = 1'b0;

	assign mapsz_tbl[S_DEVTBL]     = pi1_data_t'(DEVTBL_MAPSZ);
	assign mapsz_tbl[S_RAM]        = pi1_data_t'(RAM_MAPSZ);
	assign mapsz_tbl[S_INVALIDDEV] = pi1_data_t'(INVALIDDEV_MAPSZ);

	// Two words per slave, id word at even offsets and map size at odd ones
	assign slot = req_offset_i[$clog2(SLAVECOUNT):1];

	always_comb begin
		rd_nxt = '0;
		if (req_op_i != PI1_WROP && req_offset_i < pi1_addr_t'(2 * SLAVECOUNT)) begin
			if (req_offset_i[0]) begin
				rd_nxt = mapsz_tbl[slot];
			end else begin
				rd_nxt = {intr_tbl[slot], 15'd0, id_tbl[slot]};
			end
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (req_valid_i) begin
			rd_data_o <= rd_nxt;
		end
	end

	assign rst_bits = req_data_i[1:0];
	assign rst_wr   = req_valid_i && (req_op_i == PI1_WROP || req_op_i == PI1_RWOP) &&
		(req_offset_i == pi1_addr_t'(RSTREG_OFFSET));

	// Code 3 and RST_NONE are ignored
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			sw_rst_req_o  <= 1'b0;
			sw_rst_code_o <= RST_NONE;
		end else begin
			sw_rst_req_o <= rst_wr && (rst_bits == RST_WARM || rst_bits == RST_PWROFF);
			if (rst_wr) begin
				sw_rst_code_o <= sw_rst_e'(rst_bits);
			end
		end
	end

endmodule

//--- src/scratch_ram.sv
// On-chip scratch RAM slave with byte selects and a read-write swap
`timescale 1ns/1ps

module scratch_ram (
	input  logic                   clk48mhz_i,
	input  logic                   req_valid_i,
	input  pi1_bus_pkg::pi1_op_e   req_op_i,
	input  pi1_bus_pkg::pi1_addr_t req_offset_i,
	input  pi1_bus_pkg::pi1_data_t req_data_i,
	input  pi1_bus_pkg::pi1_sel_t  req_sel_i,
	output pi1_bus_pkg::pi1_data_t rd_data_o
);

	import pi1_bus_pkg::*;
	import soc_map_pkg::*;

	pi1_data_t                     mem [RAM_MAPSZ];
	logic [$clog2(RAM_MAPSZ)-1:0]  word_idx;
	logic                          wr_en;

	// Decoder only routes offsets inside the window here
	assign word_idx = req_offset_i[$clog2(RAM_MAPSZ)-1:0];
	assign wr_en    = req_valid_i && (req_op_i == PI1_WROP || req_op_i == PI1_RWOP);

	// Read side, old word for reads and swaps, zero for plain writes
	always_ff @(posedge clk48mhz_i) begin
		if (req_valid_i) begin
			if (req_op_i == PI1_WROP) begin
				rd_data_o <= '0;
			end else begin
				rd_data_o <= mem[word_idx];
			end
		end
	end

	// Byte lane writes
	always_ff @(posedge clk48mhz_i) begin
		if (wr_en) begin
			for (int b = 0; b < SELBITSZ; b++) begin
				if (req_sel_i[b]) begin
					mem[word_idx][b*8 +: 8] <= req_data_i[b*8 +: 8];
				end
			end
		end
	end

endmodule

//--- src/pi1_response_mux.sv
// Bus output stage; times the response, returns the selected slave data and drives ready
`timescale 1ns/1ps

module pi1_response_mux (
	input  logic                    clk48mhz_i,
	input  logic                    rst_p,
	input  logic                    core_rst_i,
	input  logic                    busy_i,
	input  soc_map_pkg::slave_idx_e slave_sel_i,
	input  pi1_bus_pkg::pi1_data_t  devtbl_data_i,
	input  pi1_bus_pkg::pi1_data_t  ram_data_i,
	output logic                    done_o,
	output pi1_bus_pkg::pi1_data_t  pi1_data_o,
	output logic                    pi1_rdy_o
);

	import pi1_bus_pkg::*;
	import soc_map_pkg::*;

	logic [$clog2(RESP_LATENCY+1)-1:0] resp_cnt;
	pi1_data_t                         sel_data;

	// Last response cycle of the request in flight
	assign done_o = busy_i && (resp_cnt == ($bits(resp_cnt))'(RESP_LATENCY - 1));

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p || core_rst_i || !busy_i || done_o) begin
			resp_cnt <= '0;
		end else begin
			resp_cnt <= resp_cnt + 1'b1;
		end
	end

	// Default slave reads as zero
	always_comb begin
		case (slave_sel_i)
			S_DEVTBL: sel_data = devtbl_data_i;
			S_RAM:    sel_data = ram_data_i;
			default:  sel_data = '0;
		endcase
	end

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p || core_rst_i) begin
			pi1_data_o <= '0;
		end else if (done_o) begin
			pi1_data_o <= sel_data;
		end
	end

	assign pi1_rdy_o = !busy_i && !core_rst_i;

endmodule

//--- src/soc_fabric_top.sv
// Fabric top level; ties the reset sequencer, decoder, slaves and response mux together
`timescale 1ns/1ps

module soc_fabric_top (
	input  logic                   clk48mhz_i,
	input  logic                   rst_p,
	input  pi1_bus_pkg::pi1_op_e   pi1_op_i,
	input  pi1_bus_pkg::pi1_addr_t pi1_addr_i,
	input  pi1_bus_pkg::pi1_data_t pi1_data_i,
	input  pi1_bus_pkg::pi1_sel_t  pi1_sel_i,
	output pi1_bus_pkg::pi1_data_t pi1_data_o,
	output logic                   pi1_rdy_o,
	output logic                   led_green_n_o,
	output logic                   led_red_n_o
);

	import pi1_bus_pkg::*;
	import soc_map_pkg::*;

	logic       core_rst;
	logic       sw_rst_req;
	sw_rst_e    sw_rst_code;
	logic       busy;
	logic       done;
	logic       req_valid;
	pi1_op_e    req_op;
	pi1_addr_t  req_offset;
	pi1_data_t  req_data;
	pi1_sel_t   req_sel;
	slave_idx_e slave_sel;
	pi1_data_t  devtbl_data;
	pi1_data_t  ram_data;

	reset_sequencer u_reset_sequencer (
		.clk48mhz_i    (clk48mhz_i),
		.rst_p         (rst_p),
		.sw_rst_req_i  (sw_rst_req),
		.sw_rst_code_i (sw_rst_code),
		.core_rst_o    (core_rst),
		.led_green_n_o (led_green_n_o),
		.led_red_n_o   (led_red_n_o)
	);

	pi1_addr_decoder u_pi1_addr_decoder (
		.clk48mhz_i   (clk48mhz_i),
		.rst_p        (rst_p),
		.core_rst_i   (core_rst),
		.pi1_op_i     (pi1_op_i),
		.pi1_addr_i   (pi1_addr_i),
		.pi1_data_i   (pi1_data_i),
		.pi1_sel_i    (pi1_sel_i),
		.busy_o       (busy),
		.req_valid_o  (req_valid),
		.req_op_o     (req_op),
		.req_offset_o (req_offset),
		.req_data_o   (req_data),
		.req_sel_o    (req_sel),
		.slave_sel_o  (slave_sel),
		.done_i       (done)
	);

	// Each slave sees only the requests routed to it
	device_table u_device_table (
		.clk48mhz_i    (clk48mhz_i),
		.rst_p         (rst_p),
		.req_valid_i   (req_valid && (slave_sel == S_DEVTBL)),
		.req_op_i      (req_op),
		.req_offset_i  (req_offset),
		.req_data_i    (req_data),
		.rd_data_o     (devtbl_data),
		.sw_rst_req_o  (sw_rst_req),
		.sw_rst_code_o (sw_rst_code)
	);

	scratch_ram u_scratch_ram (
		.clk48mhz_i   (clk48mhz_i),
		.req_valid_i  (req_valid && (slave_sel == S_RAM)),
		.req_op_i     (req_op),
		.req_offset_i (req_offset),
		.req_data_i   (req_data),
		.req_sel_i    (req_sel),
		.rd_data_o    (ram_data)
	);

	pi1_response_mux u_pi1_response_mux (
		.clk48mhz_i    (clk48mhz_i),
		.rst_p         (rst_p),
		.core_rst_i    (core_rst),
		.busy_i        (busy),
		.slave_sel_i   (slave_sel),
		.devtbl_data_i (devtbl_data),
		.ram_data_i    (ram_data),
		.done_o        (done),
		.pi1_data_o    (pi1_data_o),
		.pi1_rdy_o     (pi1_rdy_o)
	);

endmodule

//--- testbench/tb_soc_fabric.sv
// Testbench for the fabric top level; single bus master, RAM model and checking assertions
`timescale 1ns/1ps

module tb_soc_fabric;

	import pi1_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int RST_CYCLES = 16;
	localparam int RAM_AW = $clog2(RAM_MAPSZ);
	// Accesses of the RAM fill, the four full compares and about a hundred more
	localparam int ACCESS_COUNT = 5 * RAM_MAPSZ + 128;
	// Twice the five counter runs, the power-off hold and all accesses
	localparam int CYCLE_LIMIT = 2 * (6 * (2 ** RST_CNTR_BITSZ) + ACCESS_COUNT * (RESP_LATENCY + 1));
	localparam int EXP_ID [SLAVECOUNT] = '{DEVID_DEVTBL, DEVID_RAM, DEVID_INVALIDDEV};
	localparam int EXP_MAPSZ [SLAVECOUNT] = '{DEVTBL_MAPSZ, RAM_MAPSZ, INVALIDDEV_MAPSZ};

	logic      clk48mhz_i;
	logic      rst_p;
	pi1_op_e   pi1_op_i;
	pi1_addr_t pi1_addr_i;
	pi1_data_t pi1_data_i;
	pi1_sel_t  pi1_sel_i;
	pi1_data_t pi1_data_o;
	logic      pi1_rdy_o;
	logic      led_green_n_o;
	logic      led_red_n_o;

	pi1_data_t               ram_model [RAM_MAPSZ];
	logic [15:0]             lfsr;
	int                      cycle_cnt = 0;
	logic                    accept_now;
	logic [RESP_LATENCY-1:0] acc_pipe;
	// Set while a reset register write may cut the response short
	logic                    rst_wr_flight;

	soc_fabric_top u_soc_fabric_top (
		.clk48mhz_i    (clk48mhz_i),
		.rst_p         (rst_p),
		.pi1_op_i      (pi1_op_i),
		.pi1_addr_i    (pi1_addr_i),
		.pi1_data_i    (pi1_data_i),
		.pi1_sel_i     (pi1_sel_i),
		.pi1_data_o    (pi1_data_o),
		.pi1_rdy_o     (pi1_rdy_o),
		.led_green_n_o (led_green_n_o),
		.led_red_n_o   (led_red_n_o)
	);

	initial begin
		clk48mhz_i = 1'b0;
		forever #10 clk48mhz_i = ~clk48mhz_i;
	end

	always @(posedge clk48mhz_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: the test sequence did not finish within %0d cycles", CYCLE_LIMIT);
			$display("RESULT: FAIL");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic report_failure(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		$display("RESULT: FAIL");
		$fatal(1, "stopping at the first error");
	endtask

	// A request is taken on an edge with ready high and a real op
	assign accept_now = pi1_rdy_o && (pi1_op_i != PI1_NOOP);

	// Tracks how long ago each acceptance happened
	always @(posedge clk48mhz_i) begin
		if (rst_p) begin
			acc_pipe <= '0;
		end else begin
			acc_pipe <= {acc_pipe[RESP_LATENCY-2:0], accept_now};
		end
	end

	assert property (@(posedge clk48mhz_i) disable iff (rst_p)
		(accept_now || (acc_pipe[RESP_LATENCY-2:0] != '0)) |=> !pi1_rdy_o)
		else report_failure("ready high before the response latency ran out");
	assert property (@(posedge clk48mhz_i) disable iff (rst_p || rst_wr_flight)
		acc_pipe[RESP_LATENCY-1] |=> pi1_rdy_o)
		else report_failure("ready did not return after the response latency");
	assert property (@(posedge clk48mhz_i) disable iff (rst_p)
		led_green_n_o |-> (!pi1_rdy_o && pi1_data_o == '0))
		else report_failure("bus active while the core is held in reset");
	assert property (@(posedge clk48mhz_i) disable iff (rst_p)
		!led_red_n_o |-> led_green_n_o)
		else report_failure("core running while powered off");

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		// Taps 16, 14, 13 and 11
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int n, output pi1_data_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[ARCHBITSZ-2:0], lfsr[0]};
		end
	endtask

	function automatic pi1_data_t merge_bytes(input pi1_data_t old_w, input pi1_data_t new_w,
		input pi1_sel_t sel);
		pi1_data_t r;
		r = old_w;
		for (int b = 0; b < SELBITSZ; b++) begin
			if (sel[b]) begin
				r[b*8 +: 8] = new_w[b*8 +: 8];
			end
		end
		return r;
	endfunction

	// Every byte carries the word index
	function automatic pi1_data_t fill_word(input int idx);
		return (pi1_data_t'(idx) * 32'h0101_0101) ^ 32'hA5C3_3CA5;
	endfunction

	// Entered on a falling edge, returns on the falling edge after acceptance
	task automatic issue_request(input pi1_op_e op, input pi1_addr_t addr, input pi1_data_t data,
		input pi1_sel_t sel);
		pi1_op_i   = op;
		pi1_addr_i = addr;
		pi1_data_i = data;
		pi1_sel_i  = sel;
		// Held on the bus while ready is low
		while (!pi1_rdy_o) begin
			@(negedge clk48mhz_i);
		end
		@(negedge clk48mhz_i);
		pi1_op_i = PI1_NOOP;
	endtask

	task automatic wait_ready();
		while (!pi1_rdy_o) begin
			@(negedge clk48mhz_i);
		end
	endtask

	task automatic bus_access(input pi1_op_e op, input pi1_addr_t addr, input pi1_data_t data,
		input pi1_sel_t sel, output pi1_data_t rdata);
		issue_request(op, addr, data, sel);
		wait_ready();
		rdata = pi1_data_o;
	endtask

	task automatic write_word(input pi1_addr_t addr, input pi1_data_t data, input pi1_sel_t sel);
		pi1_data_t rdata;
		bus_access(PI1_WROP, addr, data, sel, rdata);
		assert (rdata == '0)
			else report_failure($sformatf("write to %0h returned %h", addr, rdata));
	endtask

	task automatic read_check(input pi1_addr_t addr, input pi1_data_t exp, input string what);
		pi1_data_t rdata;
		bus_access(PI1_RDOP, addr, '0, '1, rdata);
		assert (rdata == exp)
			else report_failure($sformatf("%s at %0h read %h, expected %h", what, addr, rdata, exp));
	endtask

	task automatic compare_ram();
		for (int i = 0; i < RAM_MAPSZ; i++) begin
			read_check(pi1_addr_t'(RAM_BASE + i), ram_model[i], "RAM word");
		end
	endtask

	// Green LED and ready stay off while the counter runs down
	task automatic wait_boot();
		int n;
		n = 0;
		while (!pi1_rdy_o) begin
			assert (led_green_n_o && led_red_n_o)
				else report_failure("LED levels wrong while the reset counter runs");
			@(negedge clk48mhz_i);
			n++;
		end
		assert (n > 0 && n <= 2 ** RST_CNTR_BITSZ && !led_green_n_o && led_red_n_o)
			else report_failure($sformatf("core came out of reset after %0d cycles", n));
	endtask

	task automatic apply_reset();
		@(negedge clk48mhz_i);
		rst_p    = 1'b1;
		pi1_op_i = PI1_NOOP;
		repeat (RST_CYCLES) @(negedge clk48mhz_i);
		rst_p = 1'b0;
		wait_boot();
	endtask

	initial begin
		pi1_data_t v;
		pi1_data_t wdata;
		pi1_data_t rdata;
		pi1_sel_t  sel;
		pi1_addr_t addr;
		int        idx;
		int        n;
		rst_p         = 1'b1;
		pi1_op_i      = PI1_NOOP;
		pi1_addr_i    = '0;
		pi1_data_i    = '0;
		pi1_sel_i     = '0;
		rst_wr_flight = 1'b0;
		lfsr          = 16'd93;
		apply_reset();

		// Device table words for every slave
		for (int k = 0; k < SLAVECOUNT; k++) begin
			read_check(pi1_addr_t'(DEVTBL_BASE + 2 * k), {1'b0, 15'd0, 16'(EXP_ID[k])}, "device id");
			read_check(pi1_addr_t'(DEVTBL_BASE + 2 * k + 1), pi1_data_t'(EXP_MAPSZ[k]), "map size");
		end
		// Button reset with a nonzero map size still on the bus data
		apply_reset();
		read_check(pi1_addr_t'(DEVTBL_BASE + RSTREG_OFFSET), '0, "reset register");

		for (int i = 0; i < RAM_MAPSZ; i++) begin
			write_word(pi1_addr_t'(RAM_BASE + i), fill_word(i), '1);
			ram_model[i] = fill_word(i);
		end
		repeat (64) begin
			random_bits(RAM_AW, v);
			idx = int'(v[RAM_AW-1:0]);
			random_bits(ARCHBITSZ, wdata);
			random_bits(SELBITSZ, v);
			sel = v[SELBITSZ-1:0];
			write_word(pi1_addr_t'(RAM_BASE + idx), wdata, sel);
			ram_model[idx] = merge_bytes(ram_model[idx], wdata, sel);
		end
		compare_ram();

		// Swap returns the old word
		repeat (16) begin
			random_bits(RAM_AW, v);
			idx = int'(v[RAM_AW-1:0]);
			random_bits(ARCHBITSZ, wdata);
			random_bits(SELBITSZ, v);
			sel = v[SELBITSZ-1:0];
			bus_access(PI1_RWOP, pi1_addr_t'(RAM_BASE + idx), wdata, sel, rdata);
			assert (rdata == ram_model[idx])
				else report_failure($sformatf("swap at word %0d returned %h", idx, rdata));
			ram_model[idx] = merge_bytes(ram_model[idx], wdata, sel);
		end

		// Unmapped space reads zero and leaves the RAM alone
		write_word(pi1_addr_t'(INVALIDDEV_BASE), 32'hDEAD_BEEF, '1);
		read_check(pi1_addr_t'(INVALIDDEV_BASE), '0, "unmapped read");
		write_word('1, 32'h1234_5678, '1);
		read_check('1, '0, "unmapped read");
		repeat (6) begin
			random_bits(ADDRBITSZ, v);
			addr = v[ADDRBITSZ-1:0];
			if (addr < pi1_addr_t'(INVALIDDEV_BASE)) begin
				addr = addr + pi1_addr_t'(INVALIDDEV_BASE);
			end
			random_bits(ARCHBITSZ, wdata);
			write_word(addr, wdata, '1);
			read_check(addr, '0, "unmapped read");
		end
		compare_ram();

		// Warm reset restarts the counter
		rst_wr_flight = 1'b1;
		issue_request(PI1_WROP, pi1_addr_t'(DEVTBL_BASE + RSTREG_OFFSET),
			pi1_data_t'(RST_WARM), '1);
		n = 0;
		while (!led_green_n_o && n < RESP_LATENCY + 2) begin
			@(negedge clk48mhz_i);
			n++;
		end
		assert (led_green_n_o && !pi1_rdy_o && led_red_n_o)
			else report_failure("warm reset write did not restart the core reset");
		@(negedge clk48mhz_i);
		rst_wr_flight = 1'b0;
		// First read waits out the reset on the bus
		compare_ram();

		rst_wr_flight = 1'b1;
		issue_request(PI1_WROP, pi1_addr_t'(DEVTBL_BASE + RSTREG_OFFSET),
			pi1_data_t'(RST_PWROFF), '1);
		n = 0;
		while (led_red_n_o && n < RESP_LATENCY + 2) begin
			@(negedge clk48mhz_i);
			n++;
		end
		assert (!led_red_n_o)
			else report_failure("power-off write did not light the red LED");
		repeat (2 ** RST_CNTR_BITSZ + 8) begin
			@(negedge clk48mhz_i);
			assert (!pi1_rdy_o && !led_red_n_o && led_green_n_o)
				else report_failure("core left power-off without a button reset");
		end
		apply_reset();
		rst_wr_flight = 1'b0;
		compare_ram();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- list.f
src/pi1_bus_pkg.sv
src/soc_map_pkg.sv
src/reset_sequencer.sv
src/pi1_addr_decoder.sv
src/device_table.sv
src/scratch_ram.sv
src/pi1_response_mux.sv
src/soc_fabric_top.sv
testbench/tb_soc_fabric.sv

//--- Makefile
# Verilator build and run of the fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_fabric
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
